/* logic/corePkg.sv */
package corePkg;

	// Datapath widths
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int INSTR_W    = 32;

	// Major opcodes of the supported subset
	localparam logic [6:0] OPCODE_OP     = 7'b0110011;
	localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

	// funct3 values shared by register and immediate forms
	localparam logic [2:0] FUNCT3_ADD = 3'b000;
	localparam logic [2:0] FUNCT3_SLT = 3'b010;
	localparam logic [2:0] FUNCT3_XOR = 3'b100;
	localparam logic [2:0] FUNCT3_OR  = 3'b110;
	localparam logic [2:0] FUNCT3_AND = 3'b111;

	// funct7 for register-register forms
	localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
	localparam logic [6:0] FUNCT7_SUB  = 7'b0100000;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_SLT
	} aluOp_t;

	// Execute-stage payload of one slot
	typedef struct packed {
		logic                  valid;
		aluOp_t                aluOp;
		logic [REG_ADDR_W-1:0] rd;
		logic                  writeEn;
		logic [XLEN-1:0]       opA;
		logic [XLEN-1:0]       opB;
	} issueSlot_t;

	// Writeback payload of one slot
	typedef struct packed {
		logic                  valid;
		logic                  writeEn;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       result;
	} wbSlot_t;

endpackage

/* logic/pipeStage.sv */
`timescale 1ns/100ps

module pipeStage #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     i_reset,
	input  payload_t i_data,
	output payload_t o_data
);

	// Clearing the whole payload also drops every slot valid bit
	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_data <= '0;
		end else begin
			o_data <= i_data;
		end
	end

endmodule

/* logic/instrDecode.sv */
`timescale 1ns/100ps

module instrDecode import corePkg::*; (
	input  logic [INSTR_W-1:0]    i_instr,
	output aluOp_t                o_aluOp,
	output logic [REG_ADDR_W-1:0] o_rd,
	output logic [REG_ADDR_W-1:0] o_rs1,
	output logic [REG_ADDR_W-1:0] o_rs2,
	output logic [XLEN-1:0]       o_imm,
	output logic                  o_useImm,
	output logic                  o_usesRs2,
	output logic                  o_writeEn
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       supported;

	assign opcode = i_instr[6:0];
	assign funct3 = i_instr[14:12];
	assign funct7 = i_instr[31:25];

	assign o_rd  = i_instr[11:7];
	assign o_rs1 = i_instr[19:15];
	assign o_rs2 = i_instr[24:20];

	// I-type immediate, sign extended
	assign o_imm = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};

	always_comb begin
		supported = 1'b0;
		o_aluOp   = ALU_ADD;
		o_useImm  = 1'b0;
		if (opcode == OPCODE_OP) begin
			supported = (funct7 == FUNCT7_BASE);
			case (funct3)
				FUNCT3_ADD: begin
					supported = (funct7 == FUNCT7_BASE) || (funct7 == FUNCT7_SUB);
					o_aluOp   = (funct7 == FUNCT7_SUB) ? ALU_SUB : ALU_ADD;
				end
				FUNCT3_SLT: o_aluOp = ALU_SLT;
				FUNCT3_XOR: o_aluOp = ALU_XOR;
				FUNCT3_OR:  o_aluOp = ALU_OR;
				FUNCT3_AND: o_aluOp = ALU_AND;
				default:    supported = 1'b0;
			endcase
		end else if (opcode == OPCODE_OP_IMM) begin
			supported = 1'b1;
			o_useImm  = 1'b1;
			case (funct3)
				FUNCT3_ADD: o_aluOp = ALU_ADD;
				FUNCT3_XOR: o_aluOp = ALU_XOR;
				FUNCT3_OR:  o_aluOp = ALU_OR;
				FUNCT3_AND: o_aluOp = ALU_AND;
				// SLTI and shifts are outside the subset
				default:    supported = 1'b0;
			endcase
		end
	end

	// Only register forms read rs2
	assign o_usesRs2 = supported && !o_useImm;
	// Bubbles and x0 targets write nothing
	assign o_writeEn = supported && (o_rd != '0);

endmodule

/* logic/issueControl.sv */
`timescale 1ns/100ps

module issueControl import corePkg::*; (
	input  logic                  clk,
	input  logic                  i_reset,
	input  logic                  i_valid,
	input  logic [REG_ADDR_W-1:0] i_rd0,
	input  logic                  i_writeEn0,
	input  logic [REG_ADDR_W-1:0] i_rs1Slot1,
	input  logic [REG_ADDR_W-1:0] i_rs2Slot1,
	input  logic                  i_usesRs2Slot1,
	output logic                  o_ready,
	output logic                  o_issue0,
	output logic                  o_issue1
);
	logic dependent;
	logic rs1Match;
	logic rs2Match;
	logic splitStart;
	// Set while slot 1 of a split pair waits to issue
	logic secondHalf;

	assign rs1Match = (i_rd0 == i_rs1Slot1);
	assign rs2Match = i_usesRs2Slot1 && (i_rd0 == i_rs2Slot1);

	// Slot 1 needs the result slot 0 is about to produce
	assign dependent = i_writeEn0 && (rs1Match || rs2Match);

	assign splitStart = i_valid && dependent && !secondHalf;

	// Hold the pair for one more cycle on a split
	assign o_ready = !splitStart;

	// First half sends slot 0 alone, second half slot 1 alone
	assign o_issue0 = i_valid && !secondHalf;
	assign o_issue1 = i_valid && (secondHalf || !dependent);

	always_ff @(posedge clk) begin
		if (i_reset) begin
			secondHalf <= 1'b0;
		end else begin
			secondHalf <= splitStart;
		end
	end

endmodule

/* logic/regFile.sv */
`timescale 1ns/100ps

module regFile import corePkg::*; (
	input  logic                  clk,
	input  logic                  i_reset,
	input  logic [REG_ADDR_W-1:0] i_rAddr0A,
	input  logic [REG_ADDR_W-1:0] i_rAddr0B,
	input  logic [REG_ADDR_W-1:0] i_rAddr1A,
	input  logic [REG_ADDR_W-1:0] i_rAddr1B,
	output logic [XLEN-1:0]       o_rData0A,
	output logic [XLEN-1:0]       o_rData0B,
	output logic [XLEN-1:0]       o_rData1A,
	output logic [XLEN-1:0]       o_rData1B,
	input  logic                  i_wEn0,
	input  logic [REG_ADDR_W-1:0] i_wAddr0,
	input  logic [XLEN-1:0]       i_wData0,
	input  logic                  i_wEn1,
	input  logic [REG_ADDR_W-1:0] i_wAddr1,
	input  logic [XLEN-1:0]       i_wData1
);
	// x0 has no storage
	logic [XLEN-1:0] regs [1:2**REG_ADDR_W-1];

	assign o_rData0A = (i_rAddr0A == '0) ? '0 : regs[i_rAddr0A];
	assign o_rData0B = (i_rAddr0B == '0) ? '0 : regs[i_rAddr0B];
	assign o_rData1A = (i_rAddr1A == '0) ? '0 : regs[i_rAddr1A];
	assign o_rData1B = (i_rAddr1B == '0) ? '0 : regs[i_rAddr1B];

	always_ff @(posedge clk) begin
		for (int i = 1; i < 2**REG_ADDR_W; i++) begin
			if (i_reset) begin
				regs[i] <= '0;
			end else if (i_wEn1 && (i_wAddr1 == i)) begin
				// Slot 1 is younger and wins a shared target
				regs[i] <= i_wData1;
			end else if (i_wEn0 && (i_wAddr0 == i)) begin
				regs[i] <= i_wData0;
			end
		end
	end

endmodule

/* logic/operandForward.sv */
`timescale 1ns/100ps

module operandForward import corePkg::*; (
	input  logic [REG_ADDR_W-1:0] i_rAddr0A,
	input  logic [REG_ADDR_W-1:0] i_rAddr0B,
	input  logic [REG_ADDR_W-1:0] i_rAddr1A,
	input  logic [REG_ADDR_W-1:0] i_rAddr1B,
	input  logic [XLEN-1:0]       i_rfData0A,
	input  logic [XLEN-1:0]       i_rfData0B,
	input  logic [XLEN-1:0]       i_rfData1A,
	input  logic [XLEN-1:0]       i_rfData1B,
	input  wbSlot_t               i_exResult0,
	input  wbSlot_t               i_exResult1,
	input  wbSlot_t               i_wbResult0,
	input  wbSlot_t               i_wbResult1,
	output logic [XLEN-1:0]       o_op0A,
	output logic [XLEN-1:0]       o_op0B,
	output logic [XLEN-1:0]       o_op1A,
	output logic [XLEN-1:0]       o_op1B
);

	// A candidate must be live and actually write a nonzero register
	function automatic logic isHit(
		input wbSlot_t               cand,
		input logic [REG_ADDR_W-1:0] addr
	);
		return cand.valid && cand.writeEn && (cand.rd == addr) && (addr != '0);
	endfunction

	// Youngest producer first, register file last
	function automatic logic [XLEN-1:0] pickOperand(
		input logic [REG_ADDR_W-1:0] addr,
		input logic [XLEN-1:0]       rfValue
	);
		if (isHit(i_exResult1, addr)) begin
			return i_exResult1.result;
		end
		if (isHit(i_exResult0, addr)) begin
			return i_exResult0.result;
		end
		if (isHit(i_wbResult1, addr)) begin
			return i_wbResult1.result;
		end
		if (isHit(i_wbResult0, addr)) begin
			return i_wbResult0.result;
		end
		return rfValue;
	endfunction

	always_comb begin
		o_op0A = pickOperand(i_rAddr0A, i_rfData0A);
		o_op0B = pickOperand(i_rAddr0B, i_rfData0B);
		o_op1A = pickOperand(i_rAddr1A, i_rfData1A);
		o_op1B = pickOperand(i_rAddr1B, i_rfData1B);
	end

endmodule

/* logic/aluExecute.sv */
`timescale 1ns/100ps

module aluExecute import corePkg::*; (
	input  issueSlot_t i_slot0,
	input  issueSlot_t i_slot1,
	output wbSlot_t    o_result0,
	output wbSlot_t    o_result1
);

	function automatic logic [XLEN-1:0] compute(
		input aluOp_t          op,
		input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b
	);
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_XOR: return a ^ b;
			ALU_OR:  return a | b;
			ALU_AND: return a & b;
			// Signed compare
			ALU_SLT: return {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
			default: return '0;
		endcase
	endfunction

	function automatic wbSlot_t execute(input issueSlot_t slot);
		wbSlot_t res;
		res.valid   = slot.valid;
		// An empty slot never writes
		res.writeEn = slot.valid && slot.writeEn;
		res.rd      = slot.rd;
		res.result  = compute(slot.aluOp, slot.opA, slot.opB);
		return res;
	endfunction

	assign o_result0 = execute(i_slot0);
	assign o_result1 = execute(i_slot1);

endmodule

/* logic/dualIssueCore.sv */
`timescale 1ns/100ps

module dualIssueCore import corePkg::*; (
	input  logic                   clk,
	input  logic                   i_reset,
	input  logic [2*INSTR_W-1:0]   i_instrPair,
	input  logic                   i_valid,
	output logic                   o_ready,
	output logic                   o_wbEn0,
	output logic                   o_wbEn1,
	output logic [REG_ADDR_W-1:0]  o_wbAddr0,
	output logic [REG_ADDR_W-1:0]  o_wbAddr1,
	output logic [XLEN-1:0]        o_wbData0,
	output logic [XLEN-1:0]        o_wbData1
);
	typedef issueSlot_t [1:0] issuePair_t;
	typedef wbSlot_t [1:0] wbPair_t;

	// Decode results, indexed by slot
	aluOp_t                decAluOp   [2];
	logic [REG_ADDR_W-1:0] decRd      [2];
	logic [REG_ADDR_W-1:0] decRs1     [2];
	logic [REG_ADDR_W-1:0] decRs2     [2];
	logic [XLEN-1:0]       decImm     [2];
	logic                  decUseImm  [2];
	logic                  decUsesRs2 [2];
	logic                  decWriteEn [2];

	logic [1:0]            issueEn;
	logic [XLEN-1:0]       rfDataA    [2];
	logic [XLEN-1:0]       rfDataB    [2];
	logic [XLEN-1:0]       fwdA       [2];
	logic [XLEN-1:0]       fwdB       [2];

	issuePair_t            issueIn;
	issuePair_t            issueOut;
	wbPair_t               exResult;
	wbPair_t               wbOut;
	logic [1:0]            wbEn;

	for (genvar s = 0; s < 2; s++) begin : genDecode
		instrDecode decode (
			.i_instr   (i_instrPair[s*INSTR_W +: INSTR_W]),
			.o_aluOp   (decAluOp[s]),
			.o_rd      (decRd[s]),
			.o_rs1     (decRs1[s]),
			.o_rs2     (decRs2[s]),
			.o_imm     (decImm[s]),
			.o_useImm  (decUseImm[s]),
			.o_usesRs2 (decUsesRs2[s]),
			.o_writeEn (decWriteEn[s])
		);
	end

	issueControl issueCtrl (
		.clk            (clk),
		.i_reset        (i_reset),
		.i_valid        (i_valid),
		.i_rd0          (decRd[0]),
		.i_writeEn0     (decWriteEn[0]),
		.i_rs1Slot1     (decRs1[1]),
		.i_rs2Slot1     (decRs2[1]),
		.i_usesRs2Slot1 (decUsesRs2[1]),
		.o_ready        (o_ready),
		.o_issue0       (issueEn[0]),
		.o_issue1       (issueEn[1])
	);

	regFile rf (
		.clk       (clk),
		.i_reset   (i_reset),
		.i_rAddr0A (decRs1[0]),
		.i_rAddr0B (decRs2[0]),
		.i_rAddr1A (decRs1[1]),
		.i_rAddr1B (decRs2[1]),
		.o_rData0A (rfDataA[0]),
		.o_rData0B (rfDataB[0]),
		.o_rData1A (rfDataA[1]),
		.o_rData1B (rfDataB[1]),
		.i_wEn0    (wbEn[0]),
		.i_wAddr0  (wbOut[0].rd),
		.i_wData0  (wbOut[0].result),
		.i_wEn1    (wbEn[1]),
		.i_wAddr1  (wbOut[1].rd),
		.i_wData1  (wbOut[1].result)
	);

	operandForward fwd (
		.i_rAddr0A    (decRs1[0]),
		.i_rAddr0B    (decRs2[0]),
		.i_rAddr1A    (decRs1[1]),
		.i_rAddr1B    (decRs2[1]),
		.i_rfData0A   (rfDataA[0]),
		.i_rfData0B   (rfDataB[0]),
		.i_rfData1A   (rfDataA[1]),
		.i_rfData1B   (rfDataB[1]),
		.i_exResult0  (exResult[0]),
		.i_exResult1  (exResult[1]),
		.i_wbResult0  (wbOut[0]),
		.i_wbResult1  (wbOut[1]),
		.o_op0A       (fwdA[0]),
		.o_op0B       (fwdB[0]),
		.o_op1A       (fwdA[1]),
		.o_op1B       (fwdB[1])
	);

	// Issue payloads, immediate replaces operand B
	always_comb begin
		for (int s = 0; s < 2; s++) begin
			issueIn[s].valid   = issueEn[s];
			issueIn[s].aluOp   = decAluOp[s];
			issueIn[s].rd      = decRd[s];
			issueIn[s].writeEn = decWriteEn[s];
			issueIn[s].opA     = fwdA[s];
			issueIn[s].opB     = decUseImm[s] ? decImm[s] : fwdB[s];
		end
	end

	pipeStage #(.payload_t(issuePair_t)) issueStage (
		.clk     (clk),
		.i_reset (i_reset),
		.i_data  (issueIn),
		.o_data  (issueOut)
	);

	aluExecute alu (
		.i_slot0   (issueOut[0]),
		.i_slot1   (issueOut[1]),
		.o_result0 (exResult[0]),
		.o_result1 (exResult[1])
	);

	pipeStage #(.payload_t(wbPair_t)) wbStage (
		.clk     (clk),
		.i_reset (i_reset),
		.i_data  (exResult),
		.o_data  (wbOut)
	);

	assign wbEn[0] = wbOut[0].valid && wbOut[0].writeEn;
	assign wbEn[1] = wbOut[1].valid && wbOut[1].writeEn;

	assign o_wbEn0   = wbEn[0];
	assign o_wbEn1   = wbEn[1];
	assign o_wbAddr0 = wbOut[0].rd;
	assign o_wbAddr1 = wbOut[1].rd;
	assign o_wbData0 = wbOut[0].result;
	assign o_wbData1 = wbOut[1].result;

endmodule

/* tests/tbVectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: idle gap, split expected, slot 0 instr, slot 1 instr,
//          slot 0 writeback (en, rd, value), slot 1 writeback (en, rd, value)
task automatic loadVectors();
	// Independent immediates after a long idle stretch
	addVector(5, 0, encodeImm(12'd100, 0, 3'd0, 1), encodeImm(12'hFF9, 0, 3'd0, 2),
		1, 1, 32'h0000_0064, 1, 2, 32'hFFFF_FFF9);
	// XORI and ANDI on the previous pair, execute forwarding
	addVector(0, 0, encodeImm(12'h0F0, 1, 3'd4, 3), encodeImm(12'h0FF, 2, 3'd7, 4),
		1, 3, 32'h0000_0094, 1, 4, 32'h0000_00F9);
	// ORI from two pairs back, ADD from the previous pair
	addVector(0, 0, encodeImm(12'h300, 1, 3'd6, 5), encodeReg(7'h00, 4, 3, 3'd0, 6),
		1, 5, 32'h0000_0364, 1, 6, 32'h0000_018D);
	// SUB from the register file, XOR forwarded
	addVector(0, 0, encodeReg(7'h20, 2, 1, 3'd0, 7), encodeReg(7'h00, 6, 5, 3'd4, 8),
		1, 7, 32'h0000_006B, 1, 8, 32'h0000_02E9);
	addVector(0, 0, encodeReg(7'h00, 3, 7, 3'd6, 9), encodeReg(7'h00, 5, 8, 3'd7, 10),
		1, 9, 32'h0000_00FF, 1, 10, 32'h0000_0260);
	// Signed compare in both directions
	addVector(0, 0, encodeReg(7'h00, 1, 2, 3'd2, 11), encodeReg(7'h00, 2, 1, 3'd2, 12),
		1, 11, 32'h0000_0001, 1, 12, 32'h0000_0000);
	// Slot 1 reads slot 0 result through rs1
	addVector(2, 1, encodeImm(12'h123, 0, 3'd0, 13), encodeReg(7'h00, 1, 13, 3'd0, 14),
		1, 13, 32'h0000_0123, 1, 14, 32'h0000_0187);
	// Same through rs2, right after the previous split
	addVector(0, 1, encodeImm(12'd1, 14, 3'd0, 15), encodeReg(7'h20, 15, 0, 3'd0, 16),
		1, 15, 32'h0000_0188, 1, 16, 32'hFFFF_FE78);
	// Immediate field matches rd of slot 0 but must not split
	addVector(0, 0, encodeImm(12'd5, 0, 3'd0, 17), encodeImm(12'h011, 1, 3'd4, 18),
		1, 17, 32'h0000_0005, 1, 18, 32'h0000_0075);
	// x0 target and an ECALL
	addVector(1, 0, encodeImm(12'd55, 1, 3'd0, 0), 32'h0000_0073,
		0, 0, 32'h0, 0, 0, 32'h0);
	// ADD into x0 and SLTI, which is outside the subset
	addVector(0, 0, encodeReg(7'h00, 2, 1, 3'd0, 0), encodeImm(12'd1, 1, 3'd2, 19),
		0, 0, 32'h0, 0, 0, 32'h0);
	// x0 reads as zero
	addVector(0, 0, encodeImm(12'h7AB, 0, 3'd0, 20), encodeReg(7'h00, 7, 0, 3'd6, 21),
		1, 20, 32'h0000_07AB, 1, 21, 32'h0000_006B);
	// Both slots target x22
	addVector(0, 0, encodeImm(12'h111, 0, 3'd0, 22), encodeImm(12'h222, 0, 3'd0, 22),
		1, 22, 32'h0000_0111, 1, 22, 32'h0000_0222);
	// Slot 1 value wins in execute, writeback and register file
	addVector(0, 0, encodeReg(7'h00, 0, 22, 3'd0, 23), encodeImm(12'd0, 22, 3'd0, 24),
		1, 23, 32'h0000_0222, 1, 24, 32'h0000_0222);
	addVector(0, 0, encodeImm(12'd0, 22, 3'd4, 25), encodeImm(12'h0F0, 22, 3'd7, 26),
		1, 25, 32'h0000_0222, 1, 26, 32'h0000_0020);
	addVector(2, 0, encodeReg(7'h00, 0, 22, 3'd6, 27), encodeReg(7'h20, 24, 22, 3'd0, 28),
		1, 27, 32'h0000_0222, 1, 28, 32'h0000_0000);
endtask

`endif

/* tests/tbDualIssueCore.sv */
`timescale 1ns/100ps

module tbDualIssueCore;

	localparam int TIMEOUT_CYCLES = 50;

	typedef struct packed {
		logic [7:0]  gap;
		logic        split;
		logic [63:0] pair;
		logic        en0;
		logic [4:0]  rd0;
		logic [31:0] val0;
		logic        en1;
		logic [4:0]  rd1;
		logic [31:0] val1;
	} vector_t;

	typedef struct packed {
		logic [4:0]  addr;
		logic [31:0] data;
		logic [31:0] cycle;
	} expect_t;

	logic        clk;
	logic        i_reset;
	logic [63:0] i_instrPair;
	logic        i_valid;
	logic        o_ready;
	logic        o_wbEn0;
	logic        o_wbEn1;
	logic [4:0]  o_wbAddr0;
	logic [4:0]  o_wbAddr1;
	logic [31:0] o_wbData0;
	logic [31:0] o_wbData1;

	vector_t     vectors [$];
	expect_t     expected [$];
	int          errors;
	int          checks;
	logic [31:0] cycle;

	dualIssueCore UUT (
		.clk         (clk),
		.i_reset     (i_reset),
		.i_instrPair (i_instrPair),
		.i_valid     (i_valid),
		.o_ready     (o_ready),
		.o_wbEn0     (o_wbEn0),
		.o_wbEn1     (o_wbEn1),
		.o_wbAddr0   (o_wbAddr0),
		.o_wbAddr1   (o_wbAddr1),
		.o_wbData0   (o_wbData0),
		.o_wbData1   (o_wbData1)
	);

	always #10 clk = ~clk;

	// Cycle count, read only at the falling edge
	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	function automatic logic [31:0] encodeReg(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] encodeImm(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	task automatic addVector(input logic [7:0] gap, input logic split,
		input logic [31:0] instr0, input logic [31:0] instr1,
		input logic en0, input logic [4:0] rd0, input logic [31:0] val0,
		input logic en1, input logic [4:0] rd1, input logic [31:0] val1);
		vector_t vec;
		vec.gap   = gap;
		vec.split = split;
		vec.pair  = {instr1, instr0};
		vec.en0   = en0;
		vec.rd0   = rd0;
		vec.val0  = val0;
		vec.en1   = en1;
		vec.rd1   = rd1;
		vec.val1  = val1;
		vectors.push_back(vec);
	endtask

	task automatic checkValue(input string what, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	`include "tbVectors.svh"

	task automatic retire(input logic [4:0] addr, input logic [31:0] data);
		expect_t rec;
		if (expected.size() == 0) begin
			errors++;
			$display("Unexpected writeback to x%0d at %0t ns", addr, $time);
		end else begin
			rec = expected.pop_front();
			checkValue("writeback address", addr, rec.addr);
			checkValue("writeback data", data, rec.data);
			checkValue("writeback cycle", cycle, rec.cycle);
		end
	endtask

	// Slot 0 retires before slot 1 within a cycle
	always @(negedge clk) begin
		if (i_reset === 1'b0) begin
			if (o_wbEn0) begin
				retire(o_wbAddr0, o_wbData0);
			end
			if (o_wbEn1) begin
				retire(o_wbAddr1, o_wbData1);
			end
		end
	end

	initial begin
		vector_t     vec;
		expect_t     rec;
		int          stall;
		int          waitCycles;
		logic [31:0] firstCycle;
		logic        timedOut;
		errors      = 0;
		checks      = 0;
		cycle       = '0;
		timedOut    = 1'b0;
		clk         = 1'b0;
		i_reset     = 1'b1;
		i_valid     = 1'b0;
		i_instrPair = '0;
		loadVectors();
		repeat (10) @(posedge clk);
		i_reset <= 1'b0;

		for (int v = 0; v < vectors.size() && !timedOut; v++) begin
			vec = vectors[v];
			repeat (vec.gap) begin
				@(posedge clk);
				i_valid <= 1'b0;
				@(negedge clk);
				checkValue("o_ready while idle", o_ready, 1'b1);
			end
			@(posedge clk);
			i_valid     <= 1'b1;
			i_instrPair <= vec.pair;
			@(negedge clk);
			firstCycle = cycle;
			stall = 0;
			while (!o_ready && !timedOut) begin
				stall++;
				if (stall > TIMEOUT_CYCLES) begin
					timedOut = 1'b1;
					$display("Timeout: o_ready stayed low on pair %0d", v);
				end else begin
					@(negedge clk);
				end
			end
			checkValue("o_ready low cycles", stall, vec.split);
			// Slot 0 issues on the first offer, slot 1 on acceptance
			if (vec.en0) begin
				rec.addr  = vec.rd0;
				rec.data  = vec.val0;
				rec.cycle = firstCycle + 2;
				expected.push_back(rec);
			end
			if (vec.en1) begin
				rec.addr  = vec.rd1;
				rec.data  = vec.val1;
				rec.cycle = cycle + 2;
				expected.push_back(rec);
			end
		end

		@(posedge clk);
		i_valid <= 1'b0;
		waitCycles = 0;
		while (expected.size() != 0 && !timedOut) begin
			waitCycles++;
			if (waitCycles > TIMEOUT_CYCLES) begin
				timedOut = 1'b1;
				$display("Timeout: %0d expected writebacks never arrived", expected.size());
			end else begin
				@(negedge clk);
			end
		end
		// Quiet tail to catch stray writebacks
		repeat (4) @(negedge clk);

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timedOut);
		if (errors == 0 && !timedOut) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* flist.f */
+incdir+tests
logic/corePkg.sv
logic/pipeStage.sv
logic/instrDecode.sv
logic/issueControl.sv
logic/regFile.sv
logic/operandForward.sv
logic/aluExecute.sv
logic/dualIssueCore.sv
tests/tbDualIssueCore.sv
